// File: flist.f
src/width_pkg.sv
src/stream_pkg.sv
src/stream_reg.sv
src/lane_counter.sv
src/pack_ctrl_fsm.sv
src/pack_buffer.sv
src/axi4s_width_convert.sv
tb/tb_axi4s_width_convert.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axi4s_width_convert -f flist.f -o sim_tb

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"
if echo "$out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: src/axi4s_width_convert.sv
`timescale 1ns/100ps
`default_nettype none

module axi4s_width_convert (
    input  wire                  aclk,
    input  wire                  rst,
    input  wire                  aclken,
    input  wire                  endian,

    input  wire stream_pkg::s_beat_t s_beat,
    input  wire                  s_valid,
    output wire                  s_ready,

    output wire stream_pkg::m_beat_t m_beat,
    output wire                  m_valid,
    input  wire                  m_ready
);

    stream_pkg::s_beat_t              in_beat;
    wire                              in_valid;
    wire                              in_ready;

    stream_pkg::m_beat_t              word;
    wire                              word_valid;
    wire                              word_ready;

    wire                              beat_take;
    wire                              word_done;
    wire                              word_full;
    wire [width_pkg::slot_width-1:0]  slot;

    // ------------------------------
    // input slice
    // ------------------------------
    stream_reg #(.payload_t(stream_pkg::s_beat_t)) u_in_reg (
        .aclk    (aclk),
        .rst     (rst),
        .aclken  (aclken),
        .s_data  (s_beat),
        .s_valid (s_valid),
        .s_ready (s_ready),
        .m_data  (in_beat),
        .m_valid (in_valid),
        .m_ready (in_ready)
    );

    // ------------------------------
    // packing core
    // ------------------------------
    pack_ctrl_fsm u_ctrl (
        .aclk       (aclk),
        .rst        (rst),
        .aclken     (aclken),
        .in_valid   (in_valid),
        .in_last    (in_beat.last),
        .word_full  (word_full),
        .word_ready (word_ready),
        .in_ready   (in_ready),
        .beat_take  (beat_take),
        .word_valid (word_valid),
        .word_done  (word_done)
    );

    lane_counter u_cnt (
        .aclk      (aclk),
        .rst       (rst),
        .aclken    (aclken),
        .beat_take (beat_take),
        .word_done (word_done),
        .slot      (slot),
        .word_full (word_full)
    );

    pack_buffer u_buf (
        .aclk      (aclk),
        .rst       (rst),
        .aclken    (aclken),
        .endian    (endian),
        .beat_take (beat_take),
        .word_done (word_done),
        .slot      (slot),
        .in_beat   (in_beat),
        .word      (word)
    );

    // ------------------------------
    // output slice
    // ------------------------------
    stream_reg #(.payload_t(stream_pkg::m_beat_t)) u_out_reg (
        .aclk    (aclk),
        .rst     (rst),
        .aclken  (aclken),
        .s_data  (word),
        .s_valid (word_valid),
        .s_ready (word_ready),
        .m_data  (m_beat),
        .m_valid (m_valid),
        .m_ready (m_ready)
    );

endmodule

`default_nettype wire

// File: src/lane_counter.sv
`timescale 1ns/100ps
`default_nettype none

module lane_counter (
    input  wire                               aclk,
    input  wire                               rst,
    input  wire                               aclken,
    input  wire                               beat_take,
    input  wire                               word_done,
    output logic [width_pkg::slot_width-1:0]  slot,
    output wire                               word_full
);

    // next beat goes into the last slot
    assign word_full = (slot == width_pkg::slot_width'(width_pkg::ratio - 1));

    always_ff @(posedge aclk) begin
        if (rst) begin
            slot <= '0;
        end else if (aclken) begin
            if (word_done) begin
                slot <= '0;                // word handed over
            end else if (beat_take && !word_full) begin
                slot <= slot + 1'b1;
            end
        end
    end

    // once the last slot is written, the core must stop taking beats
    assert property (@(posedge aclk) disable iff (rst)
        aclken && beat_take && word_full |=> !beat_take);

endmodule

`default_nettype wire

// File: src/pack_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module pack_buffer (
    input  wire                              aclk,
    input  wire                              rst,
    input  wire                              aclken,
    input  wire                              endian,

    input  wire                              beat_take,
    input  wire                              word_done,
    input  wire [width_pkg::slot_width-1:0]  slot,
    input  wire stream_pkg::s_beat_t         in_beat,

    output stream_pkg::m_beat_t              word
);

    logic [width_pkg::slot_width-1:0] pos;    // physical slot in the word

    // endian high fills from the top half down
    assign pos = endian ? width_pkg::slot_width'(width_pkg::ratio - 1) - slot : slot;

    // ------------------------------
    // word assembly
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (rst) begin
            word <= '0;
        end else if (aclken) begin
            if (word_done) begin
                // unfilled lanes of the next word read zero
                word <= '0;
            end else if (beat_take) begin
                word.data[pos*width_pkg::s_num*width_pkg::byte_width +:
                          width_pkg::s_num*width_pkg::byte_width] <= in_beat.data;
                word.strb[pos*width_pkg::s_num +: width_pkg::s_num] <= in_beat.strb;
                word.last <= in_beat.last;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/pack_ctrl_fsm.sv
`timescale 1ns/100ps
`default_nettype none

module pack_ctrl_fsm (
    input  wire aclk,
    input  wire rst,
    input  wire aclken,

    input  wire in_valid,
    input  wire in_last,
    input  wire word_full,
    input  wire word_ready,

    output wire in_ready,
    output wire beat_take,
    output wire word_valid,
    output wire word_done
);

    typedef enum logic {
        st_fill,
        st_hold
    } state_t;

    state_t state;
    state_t state_next;

    // ------------------------------
    // outputs
    // ------------------------------
    assign in_ready   = (state == st_fill);
    assign beat_take  = aclken && in_valid && in_ready;
    assign word_valid = (state == st_hold);
    assign word_done  = aclken && word_valid && word_ready;    // handed to output slice

    // ------------------------------
    // next state
    // ------------------------------
    always_comb begin
        state_next = state;
        case (state)
            st_fill: begin
                // word complete or packet ends early
                if (beat_take && (in_last || word_full)) begin
                    state_next = st_hold;
                end
            end
            st_hold: begin
                if (word_done) begin
                    state_next = st_fill;
                end
            end
            default: state_next = st_fill;
        endcase
    end

    always_ff @(posedge aclk) begin
        if (rst) begin
            state <= st_fill;
        end else if (aclken) begin
            state <= state_next;
        end
    end

endmodule

`default_nettype wire

// File: src/stream_pkg.sv
`default_nettype none

package stream_pkg;

    // ------------------------------
    // narrow side beat
    // ------------------------------
    typedef struct packed {
        logic [width_pkg::s_num*width_pkg::byte_width-1:0] data;
        logic [width_pkg::s_num-1:0]                       strb;   // per byte lane
        logic                                              last;
    } s_beat_t;

    // ------------------------------
    // wide side beat
    // ------------------------------
    typedef struct packed {
        logic [width_pkg::m_num*width_pkg::byte_width-1:0] data;
        logic [width_pkg::m_num-1:0]                       strb;
        logic                                              last;   // end of packet
    } m_beat_t;

endpackage

`default_nettype wire

// File: src/stream_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stream_reg #(
    parameter type payload_t = logic
) (
    input  wire           aclk,
    input  wire           rst,
    input  wire           aclken,

    input  wire payload_t s_data,
    input  wire           s_valid,
    output wire           s_ready,

    output payload_t      m_data,
    output logic          m_valid,
    input  wire           m_ready
);

    // room when empty or when the held entry leaves now
    assign s_ready = !m_valid || m_ready;

    // ------------------------------
    // occupancy
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (rst) begin
            m_valid <= 1'b0;
        end else if (aclken) begin
            if (s_valid && s_ready) begin
                m_valid <= 1'b1;    // refill, possibly while draining
            end else if (m_ready) begin
                m_valid <= 1'b0;
            end
        end
    end

    // ------------------------------
    // payload
    // ------------------------------
    always_ff @(posedge aclk) begin
        if (aclken && s_valid && s_ready) begin
            m_data <= s_data;
        end
    end

    // a stalled beat stays offered and unchanged
    assert property (@(posedge aclk) disable iff (rst)
        aclken && m_valid && !m_ready |=> m_valid && $stable(m_data));

endmodule

`default_nettype wire

// File: src/width_pkg.sv
`default_nettype none

package width_pkg;

    // ------------------------------
    // lane geometry
    // ------------------------------
    localparam int byte_width = 8;     // bits per byte lane
    localparam int s_num      = 4;     // input byte lanes
    localparam int m_num      = 8;     // output byte lanes

    // input beats per output word, power of two only
    localparam int ratio      = m_num / s_num;

    // slot index, kept at least one bit wide
    localparam int slot_width = (ratio > 1) ? $clog2(ratio) : 1;

endpackage

`default_nettype wire

// File: tb/tb_axi4s_width_convert.sv
`timescale 1ns/100ps
`default_nettype none

module tb_axi4s_width_convert;

    logic                     aclk;
    logic                     rst;
    logic                     aclken;
    logic                     endian;
    logic                     s_valid;
    logic                     m_ready;
    wire                      s_ready;
    wire                      m_valid;
    stream_pkg::s_beat_t      s_beat;
    wire stream_pkg::m_beat_t m_beat;

    stream_pkg::m_beat_t exp_q[$];          // words still owed by the running test
    string               cur_test = "reset";
    string               tag = "";          // lookahead token of the case file
    int                  extra_cnt = 0;
    int                  cycle_cnt = 0;
    int                  cycle_limit = 200;

    axi4s_width_convert uut (.*);

    initial begin
        aclk = 1'b0;
        forever #20 aclk = ~aclk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_beat(input string name, input stream_pkg::m_beat_t exp,
                              input stream_pkg::m_beat_t act);
        if (act !== exp) begin
            abort_run($sformatf("mismatch in %s: expected %h %h %b, actual %h %h %b",
                name, exp.data, exp.strb, exp.last, act.data, act.strb, act.last));
        end
    endtask

    task automatic check_done(input string name);
        if (extra_cnt != 0) begin
            abort_run($sformatf("%s: %0d output words came out that were never expected",
                name, extra_cnt));
        end else if (exp_q.size() != 0) begin
            abort_run($sformatf("%s: %0d expected words never came out", name, exp_q.size()));
        end
    endtask

    // ------------------------------
    // one test from the case file
    // ------------------------------
    task automatic run_test(input int fd);
        int                                                endn;
        int                                                gap;
        int                                                wait_cnt;
        bit                                                took;
        logic [width_pkg::m_num*width_pkg::byte_width-1:0] dat;
        logic [width_pkg::m_num-1:0]                       stb;
        logic                                              lst;
        stream_pkg::s_beat_t                               beats[$];
        void'($fscanf(fd, "%s %d", cur_test, endn));
        endian = endn[0];    // DUT is empty here
        while ($fscanf(fd, "%s", tag) == 1 && tag != "t") begin
            void'($fscanf(fd, "%h %h %h", dat, stb, lst));
            if (tag == "i") begin
                beats.push_back(stream_pkg::s_beat_t'{
                    data: dat[width_pkg::s_num*width_pkg::byte_width-1:0],
                    strb: stb[width_pkg::s_num-1:0],
                    last: lst});
            end else begin
                exp_q.push_back(stream_pkg::m_beat_t'{data: dat, strb: stb, last: lst});
            end
        end
        cycle_limit = cycle_limit + 20 * beats.size();
        gap = 0;
        while (beats.size() > 0 || s_valid) begin
            aclken  = ($urandom_range(3) != 0);
            m_ready = ($urandom_range(2) != 0);    // back-pressure
            if (!s_valid && beats.size() > 0) begin
                if (gap == 0) begin
                    s_beat  = beats.pop_front();
                    s_valid = 1'b1;
                end else begin
                    gap = gap - 1;
                end
            end
            @(posedge aclk);
            took = s_valid && s_ready && aclken;
            @(negedge aclk);
            if (took) begin
                s_valid = 1'b0;
                gap     = $urandom_range(2);    // idle cycles before next beat
            end
        end
        aclken   = 1'b1;
        m_ready  = 1'b1;
        wait_cnt = 0;
        // outstanding words leave within a few slices
        while (exp_q.size() > 0 && wait_cnt < 16) begin
            @(negedge aclk);
            wait_cnt = wait_cnt + 1;
        end
        repeat (8) @(negedge aclk);
        check_done(cur_test);
    endtask

    // ------------------------------
    // output monitor and run limit
    // ------------------------------
    always @(posedge aclk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            abort_run($sformatf("timeout after %0d cycles, output never completed",
                cycle_limit));
        end else if (!rst && aclken && m_valid && m_ready) begin
            if (exp_q.size() == 0) begin
                extra_cnt = extra_cnt + 1;
            end else begin
                check_beat(cur_test, exp_q.pop_front(), m_beat);
            end
        end
    end

    initial begin
        int fd;
        rst     = 1'b1;
        aclken  = 1'b1;
        endian  = 1'b0;
        s_valid = 1'b0;
        m_ready = 1'b0;
        s_beat  = '0;
        void'($urandom(32'hb67d_cba8));
        fd = $fopen("tb/width_convert_cases.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open the case file tb/width_convert_cases.txt");
        end
        repeat (4) @(posedge aclk);
        @(negedge aclk);
        rst = 1'b0;
        void'($fscanf(fd, "%s", tag));
        while (tag == "t") begin
            run_test(fd);
        end
        $fclose(fd);
        // quiet tail, nothing may follow the last packet
        repeat (16) @(negedge aclk);
        check_done("end of run");
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/width_convert_cases.txt
t full_low 0
i 11111111 f 0
i 22222222 f 0
i 33333333 f 0
i 44444444 f 1
e 2222222211111111 ff 0
e 4444444433333333 ff 1
t full_high 1
i 11111111 f 0
i 22222222 f 0
i 33333333 f 0
i 44444444 f 1
i deadbeef 3 1
e 1111111122222222 ff 0
e 3333333344444444 ff 1
e deadbeef00000000 30 1
t odd_strb_low 0
i 000000aa 1 0
i 0000bb00 2 0
i 12345678 c 1
e 0000bb00000000aa 21 0
e 0000000012345678 0c 1
